// ==== all.f ====
design/graph_cu_pkg.sv
design/reset_control.sv
design/vertex_reduce_cu.sv
design/cu_arbiter_control.sv
design/graph_algorithm_control.sv
verification/graph_control_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = graph_control_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/graph_control_tb.sv ====
// Graph control testbench
module graph_control_tb import graph_cu_pkg::*; #(
	parameter int NUM_VERTEX_CU = 4
);

	localparam int total_jobs  = 56;
	localparam int cycle_limit = 200 * total_jobs + 1000;

	typedef struct packed {
		logic        ignored;
		vertex_job_t job;
	} queued_job_t;

	typedef struct packed {
		logic [31:0] ready_cycle;
		cu_tag_t     tag;
		edge_index_t address;
	} pending_read_t;

	logic             clock = 1'b0;
	logic             rstn_input;
	logic             enabled_in;
	logic [31:0]      cu_configure;
	vertex_job_t      vertex_job = '0;
	read_data_t       read_data_in = '0;
	logic             read_command_bus_grant = 1'b0;
	logic             write_command_bus_grant = 1'b0;
	logic             vertex_job_request;
	read_command_t    read_command_out;
	logic             read_command_bus_request;
	edge_data_write_t edge_data_write_out;
	count_t           vertex_job_counter_done;
	count_t           edge_job_counter_done;

	queued_job_t   job_list[total_jobs];
	pending_read_t read_queue[$];
	value_t        expected_value[256];
	bit            expected_live[256];
	bit            written[256];
	reduce_op_e    current_op = op_sum;
	bit            hold_write_grant = 1'b0;
	int            jobs_released = 0;
	int            next_job = 0;
	int            credits = 0;
	int            jobs_sent = 0;
	int            edges_sent = 0;
	int            reads_seen = 0;
	int            writes_seen = 0;
	int            cycle_count = 0;

	graph_algorithm_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) dut0 (
		.clock                   (clock),
		.rstn_input              (rstn_input),
		.enabled_in              (enabled_in),
		.cu_configure            (cu_configure),
		.vertex_job              (vertex_job),
		.read_data_in            (read_data_in),
		.read_command_bus_grant  (read_command_bus_grant),
		.write_command_bus_grant (write_command_bus_grant),
		.vertex_job_request      (vertex_job_request),
		.read_command_out        (read_command_out),
		.read_command_bus_request(read_command_bus_request),
		.edge_data_write_out     (edge_data_write_out),
		.vertex_job_counter_done (vertex_job_counter_done),
		.edge_job_counter_done   (edge_job_counter_done)
	);

	always #50 clock = ~clock;

	////////////////////
	// Reference model
	////////////////////

	// Memory content at one edge address
	function automatic value_t model_value(input edge_index_t address);
		return address * 16'd7 + 16'd3;
	endfunction

	function automatic value_t reference_result(input vertex_job_t job, input reduce_op_e op);
		value_t      result;
		edge_index_t address;
		result = '0;
		for (int i = 0; i < int'(job.edge_count); i++) begin
			address = job.first_edge + edge_index_t'(i);
			if (op == op_max) begin
				if (model_value(address) > result)
					result = model_value(address);
			end else begin
				result = result + model_value(address);
			end
		end
		return result;
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_quiet_outputs();
		check_equal(32'(read_command_out.valid), 0, "read command valid");
		check_equal(32'(edge_data_write_out.valid), 0, "write valid");
		check_equal(32'(read_command_bus_request), 0, "read bus request");
		check_equal(32'(vertex_job_request), 0, "job request");
		check_equal(vertex_job_counter_done, 0, "vertex counter");
		check_equal(edge_job_counter_done, 0, "edge counter");
	endtask

	// Random jobs with unique vertex ids
	task automatic release_jobs(input int count, input bit ignored);
		queued_job_t entry;
		for (int i = 0; i < count; i++) begin
			entry.ignored         = ignored;
			entry.job.valid       = 1'b1;
			entry.job.vertex_id   = vertex_id_t'(jobs_released);
			entry.job.first_edge  = edge_index_t'($urandom);
			entry.job.edge_count  = 8'(32'd1 + $urandom % 32'd12);
			job_list[jobs_released] = entry;
			jobs_released = jobs_released + 1;
		end
	endtask

	task automatic wait_results();
		while ((next_job != jobs_released) || (writes_seen != jobs_sent))
			@(posedge clock);
	endtask

	////////////////////
	// Environment
	////////////////////

	// One job per request pulse and ignored jobs at once
	always @(negedge clock) begin
		queued_job_t head;
		if (vertex_job_request)
			credits = credits + 1;
		vertex_job = '0;
		if (next_job != jobs_released) begin
			head = job_list[next_job];
			if (head.ignored || (credits > 0)) begin
				vertex_job = head.job;
				next_job   = next_job + 1;
				if (!head.ignored) begin
					credits = credits - 1;
					expected_value[head.job.vertex_id[7:0]] =
						reference_result(head.job, current_op);
					expected_live[head.job.vertex_id[7:0]] = 1'b1;
					jobs_sent  = jobs_sent + 1;
					edges_sent = edges_sent + int'(head.job.edge_count);
				end
			end
		end
	end

	// In-order memory replies and random grants
	always @(negedge clock) begin
		pending_read_t entry;
		read_data_t    reply;
		if (read_command_out.valid) begin
			entry.ready_cycle = 32'(cycle_count) + ($urandom % 32'd6);
			entry.tag         = read_command_out.tag;
			entry.address     = read_command_out.address;
			read_queue.push_back(entry);
			reads_seen = reads_seen + 1;
		end
		reply = '0;
		if ((read_queue.size() != 0) && (read_queue[0].ready_cycle <= 32'(cycle_count))) begin
			entry       = read_queue.pop_front();
			reply.valid = 1'b1;
			reply.tag   = entry.tag;
			reply.value = model_value(entry.address);
		end
		read_data_in            = reply;
		read_command_bus_grant  = ($urandom % 32'd2) == 32'd0;
		write_command_bus_grant = !hold_write_grant && (($urandom % 32'd2) == 32'd0);
	end

	// Comparator for every result write
	always @(negedge clock) begin
		vertex_id_t vid;
		if ((rstn_input === 1'b1) && edge_data_write_out.valid) begin
			vid = edge_data_write_out.vertex_id;
			check_equal(32'((vid[15:8] == 8'd0) && expected_live[vid[7:0]] && !written[vid[7:0]]),
				1, $sformatf("unexpected or repeated write for vertex %0d", vid));
			check_equal(32'(edge_data_write_out.value), 32'(expected_value[vid[7:0]]),
				$sformatf("result for vertex %0d", vid));
			written[vid[7:0]] = 1'b1;
			writes_seen       = writes_seen + 1;
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped at cycle %0d with results still missing", cycle_count);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int writes_before;
		void'($urandom(50));
		rstn_input   = 1'b0;
		enabled_in   = 1'b1;
		cu_configure = 32'd2;
		repeat (16) @(negedge clock);
		check_quiet_outputs();
		rstn_input = 1'b1;
		repeat (2) @(negedge clock);
		check_quiet_outputs();
		cu_configure = '0;

		// Sum jobs
		@(posedge clock);
		release_jobs(20, 1'b0);
		wait_results();

		// Max jobs
		@(negedge clock);
		cu_configure = 32'd1;
		current_op   = op_max;
		@(negedge clock);
		cu_configure = '0;
		@(posedge clock);
		release_jobs(20, 1'b0);
		wait_results();

		// Results wait while the write grant is held low
		@(posedge clock);
		hold_write_grant = 1'b1;
		writes_before    = writes_seen;
		release_jobs(8, 1'b0);
		repeat (100) @(posedge clock);
		check_equal(writes_seen, writes_before, "writes while write grant held low");
		hold_write_grant = 1'b0;
		wait_results();

		// Jobs sent while disabled must vanish
		@(negedge clock);
		enabled_in = 1'b0;
		repeat (4) @(posedge clock);
		writes_before = writes_seen;
		release_jobs(4, 1'b1);
		while (next_job != jobs_released)
			@(posedge clock);
		repeat (20) @(posedge clock);
		check_equal(writes_seen, writes_before, "writes while disabled");
		check_equal(32'(read_command_bus_request), 0, "read request while disabled");
		check_equal(vertex_job_counter_done, jobs_sent, "vertex counter while disabled");
		check_equal(edge_job_counter_done, edges_sent, "edge counter while disabled");
		@(negedge clock);
		enabled_in = 1'b1;
		repeat (4) @(posedge clock);
		release_jobs(4, 1'b0);
		wait_results();

		repeat (4) @(posedge clock);
		check_equal(reads_seen, edges_sent, "read commands issued");
		check_equal(vertex_job_counter_done, jobs_sent, "final vertex counter");
		check_equal(edge_job_counter_done, edges_sent, "final edge counter");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== design/graph_algorithm_control.sv ====
// Graph algorithm control top
module graph_algorithm_control import graph_cu_pkg::*; #(
	parameter int NUM_VERTEX_CU = default_num_vertex_cu
) (
	input  logic             clock,
	input  logic             rstn_input,
	input  logic             enabled_in,
	input  logic [31:0]      cu_configure,
	input  vertex_job_t      vertex_job,
	input  read_data_t       read_data_in,
	input  logic             read_command_bus_grant,
	input  logic             write_command_bus_grant,
	output logic             vertex_job_request,
	output read_command_t    read_command_out,
	output logic             read_command_bus_request,
	output edge_data_write_t edge_data_write_out,
	output count_t           vertex_job_counter_done,
	output count_t           edge_job_counter_done
);

	logic        rstn_core;
	logic        rstn_capture;
	logic        rstn_drive;
	logic        cu_rstn;
	logic        enabled;
	logic [31:0] cu_configure_latched;
	reduce_op_e  reduce_op;

	vertex_job_t vertex_job_payload;
	vertex_job_t vertex_job_latched;
	logic        vertex_job_valid;
	read_data_t  read_data_payload;
	read_data_t  read_data_latched;
	logic        read_data_valid;
	logic        read_grant_latched;
	logic        write_grant_latched;

	vertex_job_t [NUM_VERTEX_CU-1:0]      vertex_job_cu;
	read_command_t [NUM_VERTEX_CU-1:0]    read_command_cu;
	read_data_t [NUM_VERTEX_CU-1:0]       read_data_cu;
	edge_data_write_t [NUM_VERTEX_CU-1:0] edge_data_write_cu;
	logic [NUM_VERTEX_CU-1:0]             idle_cu;
	logic [NUM_VERTEX_CU-1:0]             read_request_cu;
	logic [NUM_VERTEX_CU-1:0]             read_grant_cu;
	logic [NUM_VERTEX_CU-1:0]             write_request_cu;
	logic [NUM_VERTEX_CU-1:0]             write_grant_cu;
	logic [NUM_VERTEX_CU-1:0]             edges_done_cu;
	logic [NUM_VERTEX_CU-1:0]             vertex_done_cu;

	logic             job_request_arb;
	logic             read_bus_request_arb;
	read_command_t    read_command_arb;
	edge_data_write_t edge_data_write_arb;
	count_t           vertex_count_arb;
	count_t           edge_count_arb;

	////////////////////
	// Reset and enable
	////////////////////

	// Separate copies for core, input and output flops
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			rstn_core    <= 1'b0;
			rstn_capture <= 1'b0;
			rstn_drive   <= 1'b0;
		end else begin
			rstn_core    <= 1'b1;
			rstn_capture <= 1'b1;
			rstn_drive   <= 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn_capture) begin
		if (!rstn_capture) begin
			enabled              <= 1'b0;
			vertex_job_valid     <= 1'b0;
			read_data_valid      <= 1'b0;
			read_grant_latched   <= 1'b0;
			write_grant_latched  <= 1'b0;
			cu_configure_latched <= '0;
		end else begin
			enabled             <= enabled_in;
			vertex_job_valid    <= enabled && vertex_job.valid;
			read_data_valid     <= enabled && read_data_in.valid;
			read_grant_latched  <= enabled && read_command_bus_grant;
			write_grant_latched <= enabled && write_command_bus_grant;
			// Zero word means no update
			if (|cu_configure)
				cu_configure_latched <= cu_configure;
		end
	end

	always_ff @(posedge clock) begin
		vertex_job_payload <= vertex_job;
		read_data_payload  <= read_data_in;
	end

	always_comb begin
		vertex_job_latched       = vertex_job_payload;
		vertex_job_latched.valid = vertex_job_valid;
		read_data_latched        = read_data_payload;
		read_data_latched.valid  = read_data_valid;
	end

	assign reduce_op = cu_configure_latched[0] ? op_max : op_sum;

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn_drive) begin
		if (!rstn_drive) begin
			vertex_job_request       <= 1'b0;
			read_command_out         <= '0;
			read_command_bus_request <= 1'b0;
			edge_data_write_out      <= '0;
			vertex_job_counter_done  <= '0;
			edge_job_counter_done    <= '0;
		end else begin
			vertex_job_request       <= job_request_arb;
			read_command_out         <= read_command_arb;
			read_command_bus_request <= read_bus_request_arb;
			edge_data_write_out      <= edge_data_write_arb;
			vertex_job_counter_done  <= vertex_count_arb;
			edge_job_counter_done    <= edge_count_arb;
		end
	end

	////////////////////
	// Units and arbiter
	////////////////////

	for (genvar i = 0; i < NUM_VERTEX_CU; i++) begin : gen_cu
		vertex_reduce_cu #(
			.CU_ID(i)
		) cu_inst (
			.clock               (clock),
			.rstn_input          (cu_rstn),
			.enabled_in          (enabled),
			.reduce_op           (reduce_op),
			.job_in              (vertex_job_cu[i]),
			.read_data_in        (read_data_cu[i]),
			.read_command_grant  (read_grant_cu[i]),
			.write_grant         (write_grant_cu[i]),
			.idle                (idle_cu[i]),
			.read_command_out    (read_command_cu[i]),
			.read_command_request(read_request_cu[i]),
			.edge_data_write_out (edge_data_write_cu[i]),
			.write_request       (write_request_cu[i]),
			.edges_done_pulse    (edges_done_cu[i]),
			.vertex_done_pulse   (vertex_done_cu[i])
		);
	end

	// No job requests until the units leave reset
	cu_arbiter_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) arbiter_inst (
		.clock                   (clock),
		.rstn_input              (rstn_core),
		.enabled_in              (enabled && cu_rstn),
		.vertex_job              (vertex_job_latched),
		.idle_cu                 (idle_cu),
		.read_command_cu         (read_command_cu),
		.read_request_cu         (read_request_cu),
		.edge_data_write_cu      (edge_data_write_cu),
		.write_request_cu        (write_request_cu),
		.read_data_in            (read_data_latched),
		.read_command_bus_grant  (read_grant_latched),
		.write_command_bus_grant (write_grant_latched),
		.edges_done_cu           (edges_done_cu),
		.vertex_done_cu          (vertex_done_cu),
		.vertex_job_cu           (vertex_job_cu),
		.vertex_job_request      (job_request_arb),
		.read_grant_cu           (read_grant_cu),
		.read_data_cu            (read_data_cu),
		.read_command_out        (read_command_arb),
		.read_command_bus_request(read_bus_request_arb),
		.write_grant_cu          (write_grant_cu),
		.edge_data_write_out     (edge_data_write_arb),
		.vertex_job_counter_done (vertex_count_arb),
		.edge_job_counter_done   (edge_count_arb)
	);

	reset_control reset_inst (
		.clock        (clock),
		.external_rstn(rstn_core),
		.rstn         (cu_rstn)
	);

endmodule

// ==== design/cu_arbiter_control.sv ====
// Compute unit arbiter and dispatch
module cu_arbiter_control import graph_cu_pkg::*; #(
	parameter int NUM_VERTEX_CU = default_num_vertex_cu
) (
	input  logic                                 clock,
	input  logic                                 rstn_input,
	input  logic                                 enabled_in,
	input  vertex_job_t                          vertex_job,
	input  logic [NUM_VERTEX_CU-1:0]             idle_cu,
	input  read_command_t [NUM_VERTEX_CU-1:0]    read_command_cu,
	input  logic [NUM_VERTEX_CU-1:0]             read_request_cu,
	input  edge_data_write_t [NUM_VERTEX_CU-1:0] edge_data_write_cu,
	input  logic [NUM_VERTEX_CU-1:0]             write_request_cu,
	input  read_data_t                           read_data_in,
	input  logic                                 read_command_bus_grant,
	input  logic                                 write_command_bus_grant,
	input  logic [NUM_VERTEX_CU-1:0]             edges_done_cu,
	input  logic [NUM_VERTEX_CU-1:0]             vertex_done_cu,
	output vertex_job_t [NUM_VERTEX_CU-1:0]      vertex_job_cu,
	output logic                                 vertex_job_request,
	output logic [NUM_VERTEX_CU-1:0]             read_grant_cu,
	output read_data_t [NUM_VERTEX_CU-1:0]       read_data_cu,
	output read_command_t                        read_command_out,
	output logic                                 read_command_bus_request,
	output logic [NUM_VERTEX_CU-1:0]             write_grant_cu,
	output edge_data_write_t                     edge_data_write_out,
	output count_t                               vertex_job_counter_done,
	output count_t                               edge_job_counter_done
);

	logic [4:0] pending_jobs;
	logic [4:0] idle_count;
	logic       job_taken;
	cu_tag_t    read_last;
	cu_tag_t    read_winner;
	cu_tag_t    write_last;
	cu_tag_t    write_winner;

	function automatic logic [4:0] count_ones(input logic [NUM_VERTEX_CU-1:0] bits);
		logic [4:0] total;
		total = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++)
			total = total + 5'(bits[i]);
		return total;
	endfunction

	// Nearest requester after the last winner
	function automatic logic [NUM_VERTEX_CU-1:0] rr_pick(
		input logic [NUM_VERTEX_CU-1:0] req,
		input cu_tag_t                  last
	);
		logic [NUM_VERTEX_CU-1:0] pick;
		int                       idx;
		pick = '0;
		for (int k = NUM_VERTEX_CU; k >= 1; k--) begin
			idx = (int'(last) + k) % NUM_VERTEX_CU;
			if (req[idx]) begin
				pick      = '0;
				pick[idx] = 1'b1;
			end
		end
		return pick;
	endfunction

	////////////////////
	// Job dispatch
	////////////////////

	assign idle_count = count_ones(idle_cu);

	// Lowest idle unit takes the job
	always_comb begin
		job_taken = 1'b0;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			vertex_job_cu[i]       = vertex_job;
			vertex_job_cu[i].valid = 1'b0;
			if (vertex_job.valid && idle_cu[i] && !job_taken) begin
				vertex_job_cu[i].valid = 1'b1;
				job_taken              = 1'b1;
			end
		end
	end

	// Request pulses never sit back to back
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			vertex_job_request <= 1'b0;
			pending_jobs       <= '0;
		end else begin
			vertex_job_request <= !vertex_job_request && enabled_in &&
				(idle_count > pending_jobs);
			if (vertex_job_request && !(job_taken && (pending_jobs != 5'd0)))
				pending_jobs <= pending_jobs + 5'd1;
			else if (!vertex_job_request && job_taken && (pending_jobs != 5'd0))
				pending_jobs <= pending_jobs - 5'd1;
		end
	end

	////////////////////
	// Bus arbitration
	////////////////////

	assign read_grant_cu  = rr_pick(read_request_cu, read_last) &
		{NUM_VERTEX_CU{read_command_bus_grant}};
	assign write_grant_cu = rr_pick(write_request_cu, write_last) &
		{NUM_VERTEX_CU{write_command_bus_grant}};
	assign read_command_bus_request = |read_request_cu;

	always_comb begin
		read_command_out    = '0;
		edge_data_write_out = '0;
		read_winner         = read_last;
		write_winner        = write_last;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			if (read_grant_cu[i]) begin
				read_command_out = read_command_cu[i];
				read_winner      = cu_tag_t'(i);
			end
			if (write_grant_cu[i]) begin
				edge_data_write_out = edge_data_write_cu[i];
				write_winner        = cu_tag_t'(i);
			end
		end
	end

	// Data goes back to the unit named by its tag
	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			read_data_cu[i]       = read_data_in;
			read_data_cu[i].valid = read_data_in.valid && (read_data_in.tag == cu_tag_t'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			read_last               <= cu_tag_t'(NUM_VERTEX_CU - 1);
			write_last              <= cu_tag_t'(NUM_VERTEX_CU - 1);
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			read_last               <= read_winner;
			write_last              <= write_winner;
			vertex_job_counter_done <= vertex_job_counter_done +
				count_t'(count_ones(vertex_done_cu));
			edge_job_counter_done   <= edge_job_counter_done +
				count_t'(count_ones(edges_done_cu));
		end
	end

	a_grants_onehot : assert property (@(posedge clock) disable iff (!rstn_input)
		$onehot0(read_grant_cu) && $onehot0(write_grant_cu))
		else $error("more than one unit granted");

	// Every arriving job finds an idle unit
	a_job_placed : assert property (@(posedge clock) disable iff (!rstn_input)
		vertex_job.valid |-> job_taken)
		else $error("job for vertex %0d had no idle unit", vertex_job.vertex_id);

endmodule

// ==== design/vertex_reduce_cu.sv ====
// Vertex reduction unit
module vertex_reduce_cu import graph_cu_pkg::*; #(
	parameter int CU_ID = 0
) (
	input  logic             clock,
	input  logic             rstn_input,
	input  logic             enabled_in,
	input  reduce_op_e       reduce_op,
	input  vertex_job_t      job_in,
	input  read_data_t       read_data_in,
	input  logic             read_command_grant,
	input  logic             write_grant,
	output logic             idle,
	output read_command_t    read_command_out,
	output logic             read_command_request,
	output edge_data_write_t edge_data_write_out,
	output logic             write_request,
	output logic             edges_done_pulse,
	output logic             vertex_done_pulse
);

	typedef enum logic [1:0] {
		state_idle,
		state_fetch,
		state_wait_data,
		state_write_result
	} cu_state_e;

	cu_state_e   state;
	logic [7:0]  edges_left;
	vertex_id_t  vertex_id;
	edge_index_t next_edge;
	value_t      accum;
	logic        job_accept;
	logic        data_accept;

	assign job_accept  = (state == state_idle) && enabled_in && job_in.valid;
	assign data_accept = (state == state_wait_data) && read_data_in.valid;

	// One command in flight until its datum returns
	always_ff @(posedge clock or negedge rstn_input) begin
		if (!rstn_input) begin
			state      <= state_idle;
			edges_left <= '0;
		end else begin
			case (state)
				state_idle: begin
					if (job_accept) begin
						state      <= state_fetch;
						edges_left <= job_in.edge_count;
					end
				end
				state_fetch: begin
					if (read_command_grant)
						state <= state_wait_data;
				end
				state_wait_data: begin
					if (data_accept) begin
						edges_left <= edges_left - 8'd1;
						if (edges_left == 8'd1)
							state <= state_write_result;
						else
							state <= state_fetch;
					end
				end
				state_write_result: begin
					if (write_grant)
						state <= state_idle;
				end
				default: state <= state_idle;
			endcase
		end
	end

	// Job fields and running reduction
	always_ff @(posedge clock) begin
		if (job_accept) begin
			vertex_id <= job_in.vertex_id;
			next_edge <= job_in.first_edge;
			accum     <= '0;
		end
		if ((state == state_fetch) && read_command_grant)
			next_edge <= next_edge + 16'd1;
		if (data_accept) begin
			if (reduce_op == op_max) begin
				if (read_data_in.value > accum)
					accum <= read_data_in.value;
			end else begin
				accum <= accum + read_data_in.value;
			end
		end
	end

	assign idle                 = (state == state_idle);
	assign read_command_request = (state == state_fetch);
	assign write_request        = (state == state_write_result);
	assign edges_done_pulse     = data_accept;
	assign vertex_done_pulse    = write_request && write_grant;

	always_comb begin
		read_command_out.valid   = read_command_request;
		read_command_out.tag     = cu_tag_t'(CU_ID);
		read_command_out.address = next_edge;

		edge_data_write_out.valid     = write_request;
		edge_data_write_out.vertex_id = vertex_id;
		edge_data_write_out.value     = accum;
	end

	// Idle units never win the read bus
	a_no_request_when_idle : assert property (@(posedge clock) disable iff (!rstn_input)
		idle |-> !read_command_grant)
		else $error("unit %0d granted a read command while idle", CU_ID);

	// Arbiter must route data by tag
	a_data_tag_match : assert property (@(posedge clock) disable iff (!rstn_input)
		read_data_in.valid |-> (read_data_in.tag == cu_tag_t'(CU_ID)))
		else $error("unit %0d got data tagged %0d", CU_ID, read_data_in.tag);

endmodule

// ==== design/reset_control.sv ====
// Compute unit reset release
module reset_control (
	input  logic clock,
	input  logic external_rstn,
	output logic rstn
);

	localparam logic [2:0] hold_cycles = 3'd4;

	logic [1:0] sync_stage;
	logic [2:0] hold_count;

	// Two flops, then a short count before release
	always_ff @(posedge clock or negedge external_rstn) begin
		if (!external_rstn) begin
			sync_stage <= '0;
			hold_count <= '0;
			rstn       <= 1'b0;
		end else begin
			sync_stage <= {sync_stage[0], 1'b1};
			if (sync_stage[1] && (hold_count != hold_cycles))
				hold_count <= hold_count + 3'd1;
			rstn <= (hold_count == hold_cycles);
		end
	end

endmodule

// ==== design/graph_cu_pkg.sv ====
// Graph control shared types
package graph_cu_pkg;

	// Default unit count for the top level
	parameter int default_num_vertex_cu = 4;

	////////////////////
	// Scalar types
	////////////////////

	typedef logic [15:0] vertex_id_t;
	typedef logic [15:0] edge_index_t;

	// Neighbor value and result, sum wraps at 16 bits
	typedef logic [15:0] value_t;

	// Unit index, at most 16 units
	typedef logic [3:0] cu_tag_t;

	// Done counters
	typedef logic [31:0] count_t;

	// Reduction select, bit 0 of the configuration word
	typedef enum logic {
		op_sum = 1'b0,
		op_max = 1'b1
	} reduce_op_e;

	////////////////////
	// Bus records
	////////////////////

	// One vertex job, edge count is never zero
	typedef struct packed {
		logic        valid;
		vertex_id_t  vertex_id;
		edge_index_t first_edge;
		logic [7:0]  edge_count;
	} vertex_job_t;

	typedef struct packed {
		logic        valid;
		cu_tag_t     tag;
		edge_index_t address;
	} read_command_t;

	// Returned neighbor value, tag names the unit
	typedef struct packed {
		logic    valid;
		cu_tag_t tag;
		value_t  value;
	} read_data_t;

	typedef struct packed {
		logic       valid;
		vertex_id_t vertex_id;
		value_t     value;
	} edge_data_write_t;

endpackage
